// File: tb/vc_tests.txt
# path sop eop hdr(hex) tc tag(hex) port ; port is the expected output for rx beats
# run <test name> <back-pressure 0/1> sends the beats collected since the last run
tx0 1 0 40 0 00000101 0
tx0 0 0 40 0 00000302 0
tx0 0 1 40 0 00000103 0
tx0 1 1 60 1 00000204 0
run single_tx0 0
tx1 1 0 42 1 00001111 1
tx1 0 1 42 1 00001312 1
tx1 1 1 0b 0 00001213 1
run single_tx1 0
tx0 1 0 40 0 00002001 0
tx0 0 1 40 0 00002002 0
tx0 1 0 60 0 00002003 0
tx0 0 1 60 0 00002104 0
tx1 1 0 45 1 00003001 1
tx1 0 0 45 1 00003002 1
tx1 0 1 45 1 00003203 1
tx1 1 0 4a 1 00003004 1
tx1 0 0 4a 1 00003005 1
tx1 0 1 4a 1 00003006 1
run contention 0
rx 1 0 0a 1 00004001 0
rx 0 1 0a 1 00004002 0
run rx_unrouted_first 0
rx 1 0 40 1 00005001 1
rx 0 1 40 1 00005002 1
rx 1 0 60 0 00005103 0
rx 0 1 40 1 00005004 0
rx 1 1 4b 1 00005205 1
rx 1 1 06 0 00005006 0
run rx_routing 0
rx 1 1 42 1 00006001 1
rx 1 0 0a 0 00006002 1
rx 0 1 0a 0 00006003 1
rx 1 1 45 0 00006004 0
rx 1 1 0a 1 00006005 0
run rx_unrouted_follow 0
tx0 1 0 40 0 00007001 0
tx0 0 1 40 0 00007002 0
tx1 1 1 60 1 00007103 1
tx1 1 0 42 1 00007004 1
tx1 0 1 42 1 00007205 1
rx 1 0 4a 1 00007006 1
rx 0 1 4a 1 00007007 1
rx 1 0 0b 0 00007108 0
rx 0 0 0b 0 00007009 0
rx 0 1 0b 0 0000700a 0
run backpressure 1

// File: tb.f
source/vc_pkg.sv
source/st_if.sv
source/vc_ctrl.sv
source/tx_mux.sv
source/rx_demux.sv
source/st_reg_slice.sv
source/sonic_vc_top.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide the result from the simulation log
verilator --binary --timing --top-module tb_top -f tb.f --Mdir obj_dir -o tb_sim \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// File: tb/tb_top.sv
// reads tb/vc_tests.txt from the project root; tx order model assumes sources present packets back to back
`timescale 1ns/1ps

module tb_top;

   localparam int TIMEOUT = 2000;   // cycles per wait loop

   logic                  pld_clk = 1'b0;
   logic                  srstn;
   logic                  tx_in0_valid, tx_in0_ready, tx_in0_sop, tx_in0_eop;
   logic                  tx_in0_empty, tx_in0_err;
   logic [127:0]          tx_in0_data;
   logic                  tx_in1_valid, tx_in1_ready, tx_in1_sop, tx_in1_eop;
   logic                  tx_in1_empty, tx_in1_err;
   logic [127:0]          tx_in1_data;
   logic                  tx_out_valid, tx_out_ready, tx_out_sop, tx_out_eop;
   logic                  tx_out_empty, tx_out_err, tx_out_chan;
   logic [127:0]          tx_out_data;
   logic                  rx_in_valid, rx_in_ready, rx_in_sop, rx_in_eop, rx_in_empty;
   logic [127:0]          rx_in_data;
   logic [7:0]            rx_in_bardec;
   logic [15:0]           rx_in_be;
   logic                  rx_out0_valid, rx_out0_ready, rx_out0_sop, rx_out0_eop, rx_out0_empty;
   logic [127:0]          rx_out0_data;
   logic [7:0]            rx_out0_bardec;
   logic [15:0]           rx_out0_be;
   logic                  rx_out1_valid, rx_out1_ready, rx_out1_sop, rx_out1_eop, rx_out1_empty;
   logic [127:0]          rx_out1_data;
   logic [7:0]            rx_out1_bardec;
   logic [15:0]           rx_out1_be;

   vc_pkg::tx_beat_t tx0_stim[$], tx1_stim[$], tx0_exp[$], tx1_exp[$];
   vc_pkg::rx_beat_t rx_stim[$], rx0_exp[$], rx1_exp[$];

   int   seed;
   int   bp;              // random back-pressure on the outputs
   int   errors;
   int   tests_run;
   int   tests_failed;
   logic tx_last;         // model of the arbiter's last winner
   logic tx_in_pkt;

   sonic_vc_top dut0 (.*);

   always #5 pld_clk = ~pld_clk;

   always @(posedge pld_clk) begin
      #1;
      if (bp != 0) begin
         tx_out_ready  = ($random(seed) & 3) != 0;
         rx_out0_ready = ($random(seed) & 3) != 0;
         rx_out1_ready = ($random(seed) & 3) != 0;
      end else begin
         tx_out_ready  = 1'b1;
         rx_out0_ready = 1'b1;
         rx_out1_ready = 1'b1;
      end
   end

   task automatic check(input string sig, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         $display("ERR t=%0t %0s got=%h exp=%h", $time, sig, got, exp);
         errors++;
      end
   endtask

   function automatic logic [127:0] make_data(logic [7:0] hdr, logic tc, logic [31:0] tag);
      logic [127:0] d;
      d = {tag, tag, tag, 32'h0};
      d[31:24] = hdr;   // fmt/type byte
      d[22] = tc;
      d[21:0] = tag[21:0];
      return d;
   endfunction

   function automatic vc_pkg::tx_beat_t make_tx(int sop, int eop, logic [7:0] hdr, logic tc,
                                                logic [31:0] tag);
      vc_pkg::tx_beat_t b;
      b.data  = make_data(hdr, tc, tag);
      b.sop   = sop[0];
      b.eop   = eop[0];
      b.empty = tag[8];
      b.err   = tag[9];
      return b;
   endfunction

   function automatic vc_pkg::rx_beat_t make_rx(int sop, int eop, logic [7:0] hdr, logic tc,
                                                logic [31:0] tag);
      vc_pkg::rx_beat_t b;
      b.data   = make_data(hdr, tc, tag);
      b.sop    = sop[0];
      b.eop    = eop[0];
      b.empty  = tag[8];
      b.bardec = tag[7:0] ^ 8'h5a;
      b.be     = tag[23:8];
      return b;
   endfunction

   task automatic put_tx(input int port, input logic valid, input vc_pkg::tx_beat_t b);
      if (port == 0) begin
         tx_in0_valid = valid;
         {tx_in0_data, tx_in0_sop, tx_in0_eop, tx_in0_empty, tx_in0_err} = b;
      end else begin
         tx_in1_valid = valid;
         {tx_in1_data, tx_in1_sop, tx_in1_eop, tx_in1_empty, tx_in1_err} = b;
      end
   endtask

   task automatic put_rx(input logic valid, input vc_pkg::rx_beat_t b);
      rx_in_valid = valid;
      {rx_in_data, rx_in_sop, rx_in_eop, rx_in_empty, rx_in_bardec, rx_in_be} = b;
   endtask

   // hold each beat until the source sees ready at the clock edge
   task automatic send_tx(input int port);
      vc_pkg::tx_beat_t b;
      int               cnt;
      logic             done;
      while ((port == 0 ? tx0_stim.size() : tx1_stim.size()) > 0) begin
         b = (port == 0) ? tx0_stim.pop_front() : tx1_stim.pop_front();
         put_tx(port, 1'b1, b);
         cnt = 0;
         done = 1'b0;
         while (!done) begin
            @(negedge pld_clk);
            done = (port == 0) ? tx_in0_ready : tx_in1_ready;
            @(posedge pld_clk);
            #1;
            cnt++;
            if (!done && cnt > TIMEOUT) begin
               $display("timeout: transmit port %0d never accepted its beat", port);
               $display("STATUS: FAIL");
               $finish;
            end
         end
      end
      put_tx(port, 1'b0, '0);
   endtask

   task automatic send_rx();
      int   cnt;
      logic done;
      while (rx_stim.size() > 0) begin
         put_rx(1'b1, rx_stim.pop_front());
         cnt = 0;
         done = 1'b0;
         while (!done) begin
            @(negedge pld_clk);
            done = rx_in_ready;
            @(posedge pld_clk);
            #1;
            cnt++;
            if (!done && cnt > TIMEOUT) begin
               $display("timeout: receive input never accepted its beat");
               $display("STATUS: FAIL");
               $finish;
            end
         end
      end
      put_rx(1'b0, '0);
   endtask

   task automatic drain();
      int cnt;
      cnt = 0;
      while (tx0_exp.size() + tx1_exp.size() + rx0_exp.size() + rx1_exp.size() > 0) begin
         @(posedge pld_clk);
         #1;
         cnt++;
         if (cnt > TIMEOUT) begin
            $display("timeout: expected output beats never arrived");
            $display("STATUS: FAIL");
            $finish;
         end
      end
   endtask

   task automatic report(input string name, input int errs_before);
      tests_run++;
      if (errors != errs_before) begin
         tests_failed++;
      end
      $display("test %0s: %0s (%0d errors)", name,
               (errors == errs_before) ? "ok" : "failed", errors - errs_before);
   endtask

   task automatic check_rx(input string port, input vc_pkg::rx_beat_t got,
                           input vc_pkg::rx_beat_t exp);
      check({port, "_data"}, got.data, exp.data);
      check({port, "_sop"}, 128'(got.sop), 128'(exp.sop));
      check({port, "_eop"}, 128'(got.eop), 128'(exp.eop));
      check({port, "_empty"}, 128'(got.empty), 128'(exp.empty));
      check({port, "_bardec"}, 128'(got.bardec), 128'(exp.bardec));
      check({port, "_be"}, 128'(got.be), 128'(exp.be));
   endtask

   // sample where outputs are stable, the transfer itself is at the next rising edge
   always @(negedge pld_clk) begin
      vc_pkg::tx_beat_t exp;
      logic             pick;
      if (srstn) begin
         if (tx_out_valid && tx_out_ready) begin
            if (tx_in_pkt) begin
               pick = tx_last;
            end else if (tx0_exp.size() > 0 && tx1_exp.size() > 0) begin
               pick = ~tx_last;   // tie goes to the port that lost last
            end else begin
               pick = (tx1_exp.size() > 0);
            end
            if ((pick ? tx1_exp.size() : tx0_exp.size()) == 0) begin
               $display("t=%0t unexpected beat on tx_out", $time);
               errors++;
            end else begin
               exp = pick ? tx1_exp.pop_front() : tx0_exp.pop_front();
               check("tx_out_chan", 128'(tx_out_chan), 128'(pick));
               check("tx_out_data", tx_out_data, exp.data);
               check("tx_out_sop", 128'(tx_out_sop), 128'(exp.sop));
               check("tx_out_eop", 128'(tx_out_eop), 128'(exp.eop));
               check("tx_out_empty", 128'(tx_out_empty), 128'(exp.empty));
               check("tx_out_err", 128'(tx_out_err), 128'(exp.err));
               tx_last = pick;
               tx_in_pkt = !exp.eop;
            end
         end
         if (rx_out0_valid && rx_out1_valid) begin
            $display("t=%0t both receive ports valid at once", $time);
            errors++;
         end
         if (rx_out0_valid && rx_out0_ready) begin
            if (rx0_exp.size() == 0) begin
               $display("t=%0t unexpected beat on rx_out0", $time);
               errors++;
            end else begin
               check_rx("rx_out0", {rx_out0_data, rx_out0_sop, rx_out0_eop, rx_out0_empty,
                                    rx_out0_bardec, rx_out0_be}, rx0_exp.pop_front());
            end
         end
         if (rx_out1_valid && rx_out1_ready) begin
            if (rx1_exp.size() == 0) begin
               $display("t=%0t unexpected beat on rx_out1", $time);
               errors++;
            end else begin
               check_rx("rx_out1", {rx_out1_data, rx_out1_sop, rx_out1_eop, rx_out1_empty,
                                    rx_out1_bardec, rx_out1_be}, rx1_exp.pop_front());
            end
         end
      end
   end

   initial begin
      int                fd;
      int                n;
      int                f_sop, f_eop, f_tc, f_port, errs_before;
      logic [7:0]        f_hdr;
      logic [31:0]       f_tag;
      string             line, kind, name;
      seed = 1;
      bp = 0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      tx_last = 1'b1;
      tx_in_pkt = 1'b0;
      srstn = 1'b0;
      tx_out_ready = 1'b1;
      rx_out0_ready = 1'b1;
      rx_out1_ready = 1'b1;
      put_tx(0, 1'b0, '0);
      put_tx(1, 1'b0, '0);
      put_rx(1'b0, '0);
      repeat (10) @(posedge pld_clk);
      #1;
      srstn = 1'b1;
      @(negedge pld_clk);
      check("tx_out_valid", 128'(tx_out_valid), 128'(0));
      check("rx_out0_valid", 128'(rx_out0_valid), 128'(0));
      check("rx_out1_valid", 128'(rx_out1_valid), 128'(0));
      report("reset", 0);
      @(posedge pld_clk);
      #1;
      fd = $fopen("tb/vc_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open tb/vc_tests.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            n = (n > 0) ? $sscanf(line, "%s", kind) : 0;
            if (n < 1 || kind == "#") begin
               n = 0;   // blank or comment line
            end else if (kind == "run") begin
               n = $sscanf(line, "%s %s %d", kind, name, bp);
               errs_before = errors;
               fork
                  send_tx(0);
                  send_tx(1);
                  send_rx();
               join
               drain();
               bp = 0;
               report(name, errs_before);
            end else begin
               n = $sscanf(line, "%s %d %d %h %d %h %d", kind, f_sop, f_eop, f_hdr, f_tc,
                           f_tag, f_port);
               if (kind == "tx0") begin
                  tx0_stim.push_back(make_tx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
                  tx0_exp.push_back(make_tx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
               end else if (kind == "tx1") begin
                  tx1_stim.push_back(make_tx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
                  tx1_exp.push_back(make_tx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
               end else begin
                  rx_stim.push_back(make_rx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
                  if (f_port == 1) begin
                     rx1_exp.push_back(make_rx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
                  end else begin
                     rx0_exp.push_back(make_rx(f_sop, f_eop, f_hdr, f_tc[0], f_tag));
                  end
               end
            end
         end
         $fclose(fd);
      end
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: source/sonic_vc_top.sv
// tx_out_chan is valid with tx_out_valid; receive routing only changes on routed request headers
`timescale 1ns/1ps

module sonic_vc_top (
   input  logic                          pld_clk,
   input  logic                          srstn,

   input  logic                          tx_in0_valid,
   output logic                          tx_in0_ready,
   input  logic [vc_pkg::DATA_W-1:0]     tx_in0_data,
   input  logic                          tx_in0_sop,
   input  logic                          tx_in0_eop,
   input  logic                          tx_in0_empty,
   input  logic                          tx_in0_err,

   input  logic                          tx_in1_valid,
   output logic                          tx_in1_ready,
   input  logic [vc_pkg::DATA_W-1:0]     tx_in1_data,
   input  logic                          tx_in1_sop,
   input  logic                          tx_in1_eop,
   input  logic                          tx_in1_empty,
   input  logic                          tx_in1_err,

   output logic                          tx_out_valid,
   input  logic                          tx_out_ready,
   output logic [vc_pkg::DATA_W-1:0]     tx_out_data,
   output logic                          tx_out_sop,
   output logic                          tx_out_eop,
   output logic                          tx_out_empty,
   output logic                          tx_out_err,
   output logic                          tx_out_chan,

   input  logic                          rx_in_valid,
   output logic                          rx_in_ready,
   input  logic [vc_pkg::DATA_W-1:0]     rx_in_data,
   input  logic                          rx_in_sop,
   input  logic                          rx_in_eop,
   input  logic                          rx_in_empty,
   input  logic [vc_pkg::BARDEC_W-1:0]   rx_in_bardec,
   input  logic [vc_pkg::BE_W-1:0]       rx_in_be,

   output logic                          rx_out0_valid,
   input  logic                          rx_out0_ready,
   output logic [vc_pkg::DATA_W-1:0]     rx_out0_data,
   output logic                          rx_out0_sop,
   output logic                          rx_out0_eop,
   output logic                          rx_out0_empty,
   output logic [vc_pkg::BARDEC_W-1:0]   rx_out0_bardec,
   output logic [vc_pkg::BE_W-1:0]       rx_out0_be,

   output logic                          rx_out1_valid,
   input  logic                          rx_out1_ready,
   output logic [vc_pkg::DATA_W-1:0]     rx_out1_data,
   output logic                          rx_out1_sop,
   output logic                          rx_out1_eop,
   output logic                          rx_out1_empty,
   output logic [vc_pkg::BARDEC_W-1:0]   rx_out1_bardec,
   output logic [vc_pkg::BE_W-1:0]       rx_out1_be
);

   st_if #(.payload_t(vc_pkg::tx_beat_t)) tx_in0_st ();
   st_if #(.payload_t(vc_pkg::tx_beat_t)) tx_in1_st ();
   st_if #(.payload_t(vc_pkg::tx_beat_t)) tx_lane_st ();
   st_if #(.payload_t(vc_pkg::tx_beat_t)) tx_out_st ();
   st_if #(.payload_t(vc_pkg::rx_beat_t)) rx_in_st ();
   st_if #(.payload_t(vc_pkg::rx_beat_t)) rx_lane_st ();
   st_if #(.payload_t(vc_pkg::rx_beat_t)) rx_out0_st ();
   st_if #(.payload_t(vc_pkg::rx_beat_t)) rx_out1_st ();

   vc_pkg::chan_t grant;
   vc_pkg::chan_t rx_chan;
   vc_pkg::chan_t tx_chan_q;
   logic          tx_xfer;
   logic          tx_eop;
   logic          tx_slice_load;
   logic          rx_hs;

   // transmit sources
   assign tx_in0_st.valid   = tx_in0_valid;
   assign tx_in0_st.payload = '{data: tx_in0_data, sop: tx_in0_sop, eop: tx_in0_eop,
                                empty: tx_in0_empty, err: tx_in0_err};
   assign tx_in0_ready      = tx_in0_st.ready;

   assign tx_in1_st.valid   = tx_in1_valid;
   assign tx_in1_st.payload = '{data: tx_in1_data, sop: tx_in1_sop, eop: tx_in1_eop,
                                empty: tx_in1_empty, err: tx_in1_err};
   assign tx_in1_ready      = tx_in1_st.ready;

   // transmit sink
   assign tx_out_valid    = tx_out_st.valid;
   assign tx_out_st.ready = tx_out_ready;
   assign tx_out_data     = tx_out_st.payload.data;
   assign tx_out_sop      = tx_out_st.payload.sop;
   assign tx_out_eop      = tx_out_st.payload.eop;
   assign tx_out_empty    = tx_out_st.payload.empty;
   assign tx_out_err      = tx_out_st.payload.err;
   assign tx_out_chan     = tx_chan_q;

   assign tx_slice_load = tx_lane_st.valid && tx_lane_st.ready;

   // receive source, sideband rides in the beat
   assign rx_in_st.valid   = rx_in_valid;
   assign rx_in_st.payload = '{data: rx_in_data, sop: rx_in_sop, eop: rx_in_eop,
                               empty: rx_in_empty, bardec: rx_in_bardec, be: rx_in_be};
   assign rx_in_ready      = rx_in_st.ready;

   assign rx_hs = rx_in_valid && rx_in_st.ready;

   // receive sinks
   assign rx_out0_valid    = rx_out0_st.valid;
   assign rx_out0_st.ready = rx_out0_ready;
   assign rx_out0_data     = rx_out0_st.payload.data;
   assign rx_out0_sop      = rx_out0_st.payload.sop;
   assign rx_out0_eop      = rx_out0_st.payload.eop;
   assign rx_out0_empty    = rx_out0_st.payload.empty;
   assign rx_out0_bardec   = rx_out0_st.payload.bardec;
   assign rx_out0_be       = rx_out0_st.payload.be;

   assign rx_out1_valid    = rx_out1_st.valid;
   assign rx_out1_st.ready = rx_out1_ready;
   assign rx_out1_data     = rx_out1_st.payload.data;
   assign rx_out1_sop      = rx_out1_st.payload.sop;
   assign rx_out1_eop      = rx_out1_st.payload.eop;
   assign rx_out1_empty    = rx_out1_st.payload.empty;
   assign rx_out1_bardec   = rx_out1_st.payload.bardec;
   assign rx_out1_be       = rx_out1_st.payload.be;

   vc_ctrl u_ctrl (
      .pld_clk       (pld_clk),
      .srstn         (srstn),
      .tx_valid      ({tx_in1_valid, tx_in0_valid}),
      .tx_xfer       (tx_xfer),
      .tx_eop        (tx_eop),
      .grant         (grant),
      .rx_hs         (rx_hs),
      .rx_sop        (rx_in_sop),
      .rx_hdr_byte   (rx_in_data[vc_pkg::FMT_TYPE_LSB +: 8]),
      .rx_tc_bit     (rx_in_data[vc_pkg::TC_SEL_BIT]),
      .rx_chan       (rx_chan),
      .tx_slice_load (tx_slice_load),
      .tx_out_chan   (tx_chan_q)
   );

   tx_mux u_tx_mux (
      .tx_in0  (tx_in0_st),
      .tx_in1  (tx_in1_st),
      .grant   (grant),
      .tx_lane (tx_lane_st),
      .tx_xfer (tx_xfer),
      .tx_eop  (tx_eop)
   );

   st_reg_slice #(.payload_t(vc_pkg::tx_beat_t)) u_tx_slice (
      .pld_clk (pld_clk),
      .srstn   (srstn),
      .in_s    (tx_lane_st),
      .out_s   (tx_out_st)
   );

   st_reg_slice #(.payload_t(vc_pkg::rx_beat_t)) u_rx_slice (
      .pld_clk (pld_clk),
      .srstn   (srstn),
      .in_s    (rx_in_st),
      .out_s   (rx_lane_st)
   );

   rx_demux u_rx_demux (
      .rx_lane (rx_lane_st),
      .rx_chan (rx_chan),
      .rx_out0 (rx_out0_st),
      .rx_out1 (rx_out1_st)
   );

endmodule

// File: source/st_reg_slice.sv
// one-entry stage, one cycle latency; in ready is combinational from out ready
`timescale 1ns/1ps

module st_reg_slice #(
   parameter type payload_t = logic
) (
   input logic pld_clk,
   input logic srstn,
   st_if.snk   in_s,
   st_if.src   out_s
);

   logic     full;
   payload_t beat_q;

   // accept when empty or when the held beat leaves this cycle
   assign in_s.ready = !full || out_s.ready;

   always_ff @(posedge pld_clk) begin
      if (!srstn) begin
         full <= 1'b0;
      end else if (in_s.ready) begin
         full <= in_s.valid;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (in_s.valid && in_s.ready) begin
         beat_q <= in_s.payload;
      end
   end

   assign out_s.valid   = full;
   assign out_s.payload = beat_q;

endmodule

// File: source/rx_demux.sv
// a stalled output port stalls the whole receive path, there is no per-port buffering
`timescale 1ns/1ps

module rx_demux (
   st_if.snk            rx_lane,
   input vc_pkg::chan_t rx_chan,
   st_if.src            rx_out0,
   st_if.src            rx_out1
);

   logic sel1;

   assign sel1 = (rx_chan == 1'b1);

   // beat and sideband go to both, valid only to the chosen one
   assign rx_out0.payload = rx_lane.payload;
   assign rx_out1.payload = rx_lane.payload;

   assign rx_out0.valid = rx_lane.valid && !sel1;
   assign rx_out1.valid = rx_lane.valid && sel1;

   assign rx_lane.ready = sel1 ? rx_out1.ready : rx_out0.ready;

endmodule

// File: source/tx_mux.sv
// purely combinational; the port not granted sees ready low and must hold its beat
`timescale 1ns/1ps

module tx_mux (
   st_if.snk            tx_in0,
   st_if.snk            tx_in1,
   input vc_pkg::chan_t grant,
   st_if.src            tx_lane,
   output logic         tx_xfer,
   output logic         tx_eop
);

   always_comb begin
      if (grant == 1'b1) begin
         tx_lane.valid   = tx_in1.valid;
         tx_lane.payload = tx_in1.payload;
      end else begin
         tx_lane.valid   = tx_in0.valid;
         tx_lane.payload = tx_in0.payload;
      end
   end

   // ready only goes back to the granted source
   assign tx_in0.ready = (grant == 1'b0) && tx_lane.ready;
   assign tx_in1.ready = (grant == 1'b1) && tx_lane.ready;

   assign tx_xfer = tx_lane.valid && tx_lane.ready;
   assign tx_eop  = tx_lane.payload.eop;   // only meaningful with tx_xfer

endmodule

// File: source/vc_ctrl.sv
// fixed at two ports; grant is combinational from the valids, so sources must not drop valid early
`timescale 1ns/1ps

module vc_ctrl (
   input  logic                         pld_clk,
   input  logic                         srstn,
   input  logic [vc_pkg::NUM_PORTS-1:0] tx_valid,
   input  logic                         tx_xfer,
   input  logic                         tx_eop,
   output vc_pkg::chan_t                grant,
   input  logic                         rx_hs,
   input  logic                         rx_sop,
   input  logic [7:0]                   rx_hdr_byte,
   input  logic                         rx_tc_bit,
   output vc_pkg::chan_t                rx_chan,
   input  logic                         tx_slice_load,
   output vc_pkg::chan_t                tx_out_chan
);

   logic          locked;     // packet in progress on last_win
   vc_pkg::chan_t last_win;

   // round robin unless a packet holds the lane
   always_comb begin
      if (locked) begin
         grant = last_win;
      end else if (tx_valid[0] && tx_valid[1]) begin
         grant = ~last_win;
      end else if (tx_valid[1]) begin
         grant = 1'b1;
      end else begin
         grant = 1'b0;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (!srstn) begin
         locked   <= 1'b0;
         last_win <= 1'b1;   // port 0 wins first tie
      end else if (tx_xfer) begin
         locked   <= !tx_eop;   // single-beat packet never locks
         last_win <= grant;
      end
   end

   // follows the beat held in the tx slice
   always_ff @(posedge pld_clk) begin
      if (!srstn) begin
         tx_out_chan <= 1'b0;
      end else if (tx_slice_load) begin
         tx_out_chan <= grant;
      end
   end

   // loads with the rx slice, so it names the port of the held beat
   always_ff @(posedge pld_clk) begin
      if (!srstn) begin
         rx_chan <= 1'b0;
      end else if (rx_hs && rx_sop && vc_pkg::is_routed(rx_hdr_byte)) begin
         rx_chan <= rx_tc_bit;
      end
   end

endmodule

// File: source/st_if.sv
// valid/ready stream; a beat moves on a clock edge with both high, valid never waits on ready
`timescale 1ns/1ps

interface st_if #(
   parameter type payload_t = logic
);

   logic     valid;
   logic     ready;
   payload_t payload;

   modport src (
      output valid,
      output payload,
      input  ready
   );

   modport snk (
      input  valid,
      input  payload,
      output ready
   );

endinterface

// File: source/vc_pkg.sv
// two application ports only; empty is one bit (upper 64-bit half unused), tc select is header bit 22
package vc_pkg;

   localparam int DATA_W       = 128;
   localparam int BARDEC_W     = 8;
   localparam int BE_W         = 16;
   localparam int NUM_PORTS    = 2;
   localparam int FMT_TYPE_LSB = 24;   // fmt/type byte of header dword 0
   localparam int TC_SEL_BIT   = 22;   // msb of traffic class
   localparam int NUM_ROUTED   = 8;

   // request codes that open a new receive channel
   localparam logic [0:NUM_ROUTED-1][7:0] ROUTED_CODES = {
      8'h40, 8'h60, 8'h45, 8'h42,
      8'h4A, 8'h4B, 8'h06, 8'h0B
   };

   typedef logic [$clog2(NUM_PORTS)-1:0] chan_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              sop;
      logic              eop;
      logic              empty;   // upper half of last word unused
      logic              err;
   } tx_beat_t;

   typedef struct packed {
      logic [DATA_W-1:0]   data;
      logic                sop;
      logic                eop;
      logic                empty;
      logic [BARDEC_W-1:0] bardec;
      logic [BE_W-1:0]     be;
   } rx_beat_t;

   function automatic logic is_routed(input logic [7:0] code);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < NUM_ROUTED; i++) begin
         if (code == ROUTED_CODES[i]) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

endpackage
